/* source/decode_defines.svh */
`ifndef DECODE_DEFINES_SVH
`define DECODE_DEFINES_SVH

// Major opcodes in instr[6:2]
`define OPC_LOAD      5'b00000
`define OPC_STORE     5'b01000
`define OPC_BRANCH    5'b11000
`define OPC_JALR      5'b11001
`define OPC_JAL       5'b11011
`define OPC_AUIPC     5'b00101
`define OPC_LUI       5'b01101
`define OPC_OP_IMM    5'b00100
`define OPC_OP        5'b01100
`define OPC_SYSTEM    5'b11100

// funct3 of the integer ALU rows
`define F3_ADD        3'b000
`define F3_SLL        3'b001
`define F3_SLT        3'b010
`define F3_SLTU       3'b011
`define F3_XOR        3'b100
`define F3_SR         3'b101
`define F3_OR         3'b110
`define F3_AND        3'b111

// Load, store and branch widths/conditions
`define F3_LB         3'b000
`define F3_LH         3'b001
`define F3_LW         3'b010
`define F3_LBU        3'b100
`define F3_LHU        3'b101
`define F3_SB         3'b000
`define F3_SH         3'b001
`define F3_SW         3'b010
`define F3_BEQ        3'b000
`define F3_BNE        3'b001
`define F3_BLT        3'b100
`define F3_BGE        3'b101
`define F3_BLTU       3'b110
`define F3_BGEU       3'b111
`define F3_JALR       3'b000

// System row
`define F3_PRIV       3'b000
`define F3_CSRRW      3'b001
`define F3_CSRRS      3'b010
`define F3_CSRRC      3'b011
`define F3_CSRRWI     3'b101
`define F3_CSRRSI     3'b110
`define F3_CSRRCI     3'b111

`define F7_BASE       7'b0000000
`define F7_ALT        7'b0100000
`define F7_MULDIV     7'b0000001

`define F12_ECALL     12'b0000000_00000
`define F12_EBREAK    12'b0000000_00001
`define F12_MRET      12'b0011000_00010
`define F12_WFI       12'b0001000_00101

`define ALU_ADD       4'b0000
`define ALU_SUB       4'b0001
`define ALU_SLL       4'b0011
`define ALU_SLT       4'b0100
`define ALU_SLTU      4'b0101
`define ALU_XOR       4'b0110
`define ALU_SRL       4'b0111
`define ALU_SRA       4'b1000
`define ALU_OR        4'b1001
`define ALU_AND       4'b1010
`define ALU_LUI       4'b1100

`define UNIT_ALU      2'b00
`define UNIT_MDU      2'b01
`define UNIT_CSR      2'b11

`define WB_ALU        2'b00
`define WB_LOAD       2'b01
`define WB_PC4        2'b11

`define EXC_NONE      2'b00
`define EXC_ILLEGAL   2'b01
`define EXC_ECALL     2'b10
`define EXC_EBREAK    2'b11

`endif

/* source/decode_pkg.sv */
package decode_pkg;

   // Instruction fields
   typedef logic [31:0] instr_t;
   typedef logic [4:0]  opcode_t;
   typedef logic [4:0]  reg_idx_t;
   typedef logic [2:0]  funct3_t;
   typedef logic [6:0]  funct7_t;
   typedef logic [11:0] funct12_t;

   typedef logic [3:0]  alu_op_t;

   // Same encoding as funct3 of the M row
   typedef logic [2:0]  mdu_op_t;

   // 01 write, 10 set, 11 clear
   typedef logic [1:0]  csr_op_t;

   // 00 none, 01 illegal, 10 ecall, 11 ebreak
   typedef logic [1:0]  exc_t;

   // 00 ALU, 01 MDU, 11 CSR
   typedef logic [1:0]  unit_sel_t;

   // 00 ALU result, 01 load data, 11 pc+4
   typedef logic [1:0]  wb_sel_t;

   typedef struct packed {
      logic      is_mret;
      unit_sel_t unit_sel;
      logic      csr_en;
      csr_op_t   csr_op;
      logic      csr_imm_sel;
      exc_t      exception;
      alu_op_t   alu_op;
      logic      mdu_en;
      mdu_op_t   mdu_op;
      logic      rs2_negate;
      logic      reg_wr_en;
      wb_sel_t   wb_sel;
      logic      op1_pc_sel;
      logic      op2_imm_sel;
      logic      is_load;
      logic      is_store;
   } dec_ctrl_t;

   // One per sub-decoder
   typedef struct packed {
      logic      hit;
      dec_ctrl_t ctrl;
   } dec_result_t;

endpackage

/* source/int_decoder.sv */
`timescale 1ns/100ps
`include "decode_defines.svh"

module int_decoder (
   input  decode_pkg::instr_t      instr_i,
   output decode_pkg::dec_result_t result_o
);
   import decode_pkg::*;

   opcode_t   opcode;
   funct3_t   funct3;
   funct7_t   funct7;
   logic      hit;
   dec_ctrl_t ctrl;

   assign opcode = instr_i[6:2];
   assign funct3 = instr_i[14:12];
   assign funct7 = instr_i[31:25];

   // funct3 to ALU code for the base rows
   function automatic alu_op_t base_alu_op(input funct3_t f3);
      case (f3)
         `F3_ADD:  base_alu_op = `ALU_ADD;
         `F3_SLL:  base_alu_op = `ALU_SLL;
         `F3_SLT:  base_alu_op = `ALU_SLT;
         `F3_SLTU: base_alu_op = `ALU_SLTU;
         `F3_XOR:  base_alu_op = `ALU_XOR;
         `F3_SR:   base_alu_op = `ALU_SRL;
         `F3_OR:   base_alu_op = `ALU_OR;
         default:  base_alu_op = `ALU_AND;
      endcase
   endfunction

   always_comb begin
      hit           = 1'b0;
      ctrl          = '0;
      ctrl.unit_sel = `UNIT_ALU;
      ctrl.wb_sel   = `WB_ALU;
      ctrl.alu_op   = `ALU_ADD;
      case (opcode)
         `OPC_LOAD: begin
            hit              = funct3 inside {`F3_LB, `F3_LH, `F3_LW, `F3_LBU, `F3_LHU};
            ctrl.reg_wr_en   = 1'b1;
            ctrl.wb_sel      = `WB_LOAD;
            ctrl.op2_imm_sel = 1'b1;
            ctrl.is_load     = 1'b1;
         end
         `OPC_STORE: begin
            hit              = funct3 inside {`F3_SB, `F3_SH, `F3_SW};
            ctrl.op2_imm_sel = 1'b1;
            ctrl.is_store    = 1'b1;
         end
         `OPC_BRANCH: begin
            hit = funct3 inside {`F3_BEQ, `F3_BNE, `F3_BLT, `F3_BGE, `F3_BLTU, `F3_BGEU};
            // Target address pc + imm
            ctrl.op1_pc_sel  = 1'b1;
            ctrl.op2_imm_sel = 1'b1;
         end
         `OPC_JAL, `OPC_AUIPC: begin
            hit              = 1'b1;
            ctrl.reg_wr_en   = 1'b1;
            ctrl.wb_sel      = (opcode == `OPC_JAL) ? `WB_PC4 : `WB_ALU;
            ctrl.op1_pc_sel  = 1'b1;
            ctrl.op2_imm_sel = 1'b1;
         end
         `OPC_JALR: begin
            hit              = (funct3 == `F3_JALR);
            ctrl.reg_wr_en   = 1'b1;
            ctrl.wb_sel      = `WB_PC4;
            ctrl.op2_imm_sel = 1'b1;
         end
         `OPC_LUI: begin
            hit              = 1'b1;
            ctrl.alu_op      = `ALU_LUI;
            ctrl.reg_wr_en   = 1'b1;
            ctrl.op2_imm_sel = 1'b1;
         end
         `OPC_OP_IMM: begin
            ctrl.alu_op      = base_alu_op(funct3);
            ctrl.reg_wr_en   = 1'b1;
            ctrl.op2_imm_sel = 1'b1;
            // Shifts carry funct7 above shamt
            case (funct3)
               `F3_SLL: hit = (funct7 == `F7_BASE);
               `F3_SR: begin
                  hit = (funct7 == `F7_BASE) || (funct7 == `F7_ALT);
                  if (funct7 == `F7_ALT) begin
                     ctrl.alu_op = `ALU_SRA;
                  end
               end
               default: hit = 1'b1;
            endcase
         end
         `OPC_OP: begin
            ctrl.alu_op    = base_alu_op(funct3);
            ctrl.reg_wr_en = 1'b1;
            if (funct7 == `F7_BASE) begin
               hit = 1'b1;
            end else if (funct7 == `F7_ALT) begin
               case (funct3)
                  `F3_ADD: begin
                     hit             = 1'b1;
                     ctrl.alu_op     = `ALU_SUB;
                     ctrl.rs2_negate = 1'b1;
                  end
                  `F3_SR: begin
                     hit         = 1'b1;
                     ctrl.alu_op = `ALU_SRA;
                  end
                  default: hit = 1'b0;
               endcase
            end
         end
         default: hit = 1'b0;
      endcase
      // Misses carry nothing
      if (!hit) begin
         ctrl = '0;
      end
   end

   assign result_o.hit  = hit;
   assign result_o.ctrl = ctrl;

endmodule

/* source/muldiv_decoder.sv */
`timescale 1ns/100ps
`include "decode_defines.svh"

module muldiv_decoder (
   input  decode_pkg::instr_t      instr_i,
   output decode_pkg::dec_result_t result_o
);
   import decode_pkg::*;

   opcode_t   opcode;
   funct7_t   funct7;
   logic      hit;
   dec_ctrl_t ctrl;

   assign opcode = instr_i[6:2];
   assign funct7 = instr_i[31:25];

   // All eight funct3 values are defined in the M row
   assign hit = (opcode == `OPC_OP) && (funct7 == `F7_MULDIV);

   always_comb begin
      ctrl = '0;
      if (hit) begin
         ctrl.unit_sel  = `UNIT_MDU;
         ctrl.mdu_en    = 1'b1;
         ctrl.mdu_op    = mdu_op_t'(instr_i[14:12]);
         ctrl.reg_wr_en = 1'b1;
      end
   end

   assign result_o.hit  = hit;
   assign result_o.ctrl = ctrl;

endmodule

/* source/system_decoder.sv */
`timescale 1ns/100ps
`include "decode_defines.svh"

module system_decoder (
   input  decode_pkg::instr_t      instr_i,
   output decode_pkg::dec_result_t result_o
);
   import decode_pkg::*;

   opcode_t   opcode;
   funct3_t   funct3;
   funct12_t  funct12;
   reg_idx_t  rd;
   reg_idx_t  rs1;
   logic      hit;
   dec_ctrl_t ctrl;

   assign opcode  = instr_i[6:2];
   assign funct3  = instr_i[14:12];
   assign funct12 = instr_i[31:20];
   assign rd      = instr_i[11:7];
   assign rs1     = instr_i[19:15];

   always_comb begin
      hit  = 1'b0;
      ctrl = '0;
      if (opcode == `OPC_SYSTEM) begin
         case (funct3)
            `F3_CSRRW, `F3_CSRRS, `F3_CSRRC,
            `F3_CSRRWI, `F3_CSRRSI, `F3_CSRRCI: begin
               hit              = 1'b1;
               ctrl.unit_sel    = `UNIT_CSR;
               ctrl.csr_en      = 1'b1;
               // funct3[1:0] already is the csr_op encoding
               ctrl.csr_op      = csr_op_t'(funct3[1:0]);
               ctrl.csr_imm_sel = funct3[2];
               ctrl.reg_wr_en   = 1'b1;
            end
            `F3_PRIV: begin
               if (rd == '0 && rs1 == '0) begin
                  case (funct12)
                     `F12_ECALL: begin
                        hit            = 1'b1;
                        ctrl.exception = `EXC_ECALL;
                     end
                     `F12_EBREAK: begin
                        hit            = 1'b1;
                        ctrl.exception = `EXC_EBREAK;
                     end
                     `F12_MRET: begin
                        hit          = 1'b1;
                        ctrl.is_mret = 1'b1;
                     end
                     // WFI behaves as a nop
                     `F12_WFI: hit = 1'b1;
                     default:  hit = 1'b0;
                  endcase
               end
            end
            default: hit = 1'b0;
         endcase
      end
   end

   assign result_o.hit  = hit;
   assign result_o.ctrl = ctrl;

endmodule

/* source/ctrl_merge_stage.sv */
`timescale 1ns/100ps
`include "decode_defines.svh"

module ctrl_merge_stage (
   input  logic                    clk_i,
   input  logic                    rst_n_i,
   input  logic                    instr_valid_i,
   input  decode_pkg::dec_result_t int_res_i,
   input  decode_pkg::dec_result_t mdu_res_i,
   input  decode_pkg::dec_result_t sys_res_i,
   output decode_pkg::dec_ctrl_t   ctrl_o,
   output logic                    ctrl_valid_o
);
   import decode_pkg::*;

   dec_ctrl_t sel_ctrl;

   // Decoders are mutually exclusive, so order is arbitrary
   always_comb begin
      if (int_res_i.hit) begin
         sel_ctrl = int_res_i.ctrl;
      end else if (mdu_res_i.hit) begin
         sel_ctrl = mdu_res_i.ctrl;
      end else if (sys_res_i.hit) begin
         sel_ctrl = sys_res_i.ctrl;
      end else begin
         sel_ctrl           = '0;
         sel_ctrl.exception = `EXC_ILLEGAL;
      end
   end

   // Output holds when no strobe is sampled
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         ctrl_valid_o <= 1'b0;
         ctrl_o       <= '0;
      end else begin
         ctrl_valid_o <= instr_valid_i;
         if (instr_valid_i) begin
            ctrl_o <= sel_ctrl;
         end
      end
   end

   // No encoding may be claimed by two decoders
   a_one_hit: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      instr_valid_i |-> $onehot0({int_res_i.hit, mdu_res_i.hit, sys_res_i.hit})
   ) else $error("more than one decoder hit");

   // Trapping instructions never retire a register write
   a_exc_no_wr: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      (ctrl_valid_o && ctrl_o.exception != `EXC_NONE) |-> !ctrl_o.reg_wr_en
   ) else $error("exception with reg_wr_en set");

endmodule

/* source/rv_decoder_top.sv */
`timescale 1ns/100ps

module rv_decoder_top (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  decode_pkg::instr_t    instr_i,
   input  logic                  instr_valid_i,
   output decode_pkg::dec_ctrl_t ctrl_o,
   output logic                  ctrl_valid_o
);
   import decode_pkg::*;

   dec_result_t int_res;
   dec_result_t mdu_res;
   dec_result_t sys_res;

   int_decoder u_int_dec (
      .instr_i  (instr_i),
      .result_o (int_res)
   );

   muldiv_decoder u_mdu_dec (
      .instr_i  (instr_i),
      .result_o (mdu_res)
   );

   system_decoder u_sys_dec (
      .instr_i  (instr_i),
      .result_o (sys_res)
   );

   // Single register stage
   ctrl_merge_stage u_merge (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .instr_valid_i (instr_valid_i),
      .int_res_i     (int_res),
      .mdu_res_i     (mdu_res),
      .sys_res_i     (sys_res),
      .ctrl_o        (ctrl_o),
      .ctrl_valid_o  (ctrl_valid_o)
   );

endmodule

/* tests/decode_checker.sv */
`timescale 1ns/100ps
`include "decode_defines.svh"

module decode_checker #(
   parameter int NUM_PATTERNS = 1
) (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  logic                  instr_valid_i,
   input  decode_pkg::dec_ctrl_t ctrl_i,
   input  logic                  ctrl_valid_i,
   output logic                  done_o,
   output int                    pass_count_o,
   output int                    error_count_o
);
   import decode_pkg::*;

   logic [31:0] pattern_mem [0:2*NUM_PATTERNS-1];
   int          result_idx  = 0;
   int          pass_count  = 0;
   int          error_count = 0;
   logic        done        = 1'b0;
   logic        strobe_seen = 1'b0;
   dec_ctrl_t   last_ctrl   = '0;
   dec_ctrl_t   expected;
   instr_t      instr_word;
   string       kind;

   initial begin
      $readmemh("tests/decode_patterns.txt", pattern_mem);
   end

   // Outputs are settled at the falling edge
   always @(negedge clk_i) begin
      if (!rst_n_i) begin
         if (ctrl_valid_i !== 1'b0 || ctrl_i !== '0) begin
            $display("ctrl_valid_o and ctrl_o were not cleared by reset");
            error_count = error_count + 1;
         end
         strobe_seen = 1'b0;
      end else begin
         if (ctrl_valid_i !== strobe_seen) begin
            if (ctrl_valid_i === 1'b1) begin
               $display("ctrl_valid_o rose without an instruction strobe one cycle earlier");
            end else begin
               $display("An instruction strobe gave no ctrl_valid_o one cycle later");
            end
            error_count = error_count + 1;
         end
         if (ctrl_valid_i === 1'b1) begin
            if (result_idx >= NUM_PATTERNS) begin
               $display("ctrl_valid_o seen after all patterns were checked");
               error_count = error_count + 1;
            end else begin
               instr_word = pattern_mem[2*result_idx];
               expected   = dec_ctrl_t'(pattern_mem[2*result_idx+1][$bits(dec_ctrl_t)-1:0]);
               if (expected.exception == `EXC_NONE) begin
                  kind = "no trap";
               end else begin
                  kind = "trap";
               end
               if (ctrl_i === expected) begin
                  $display("ok     pattern %0d instr %08h ctrl_o %07h (%s)",
                           result_idx, instr_word, ctrl_i, kind);
                  pass_count = pass_count + 1;
               end else begin
                  $display("FAILED pattern %0d instr %08h: ctrl_o = %07h, expected %07h",
                           result_idx, instr_word, ctrl_i, expected);
                  error_count = error_count + 1;
               end
               result_idx = result_idx + 1;
               if (result_idx == NUM_PATTERNS) begin
                  done = 1'b1;
               end
            end
            last_ctrl = ctrl_i;
         end else if (ctrl_i !== last_ctrl) begin
            $display("ctrl_o changed while ctrl_valid_o was low");
            error_count = error_count + 1;
         end
         strobe_seen = instr_valid_i;
      end
   end

   assign done_o        = done;
   assign pass_count_o  = pass_count;
   assign error_count_o = error_count;

endmodule

/* tests/tb_top.sv */
`timescale 1ns/100ps
`include "decode_defines.svh"

module tb_top;
   import decode_pkg::*;

   localparam int NUM_PATTERNS   = 38;
   localparam int TIMEOUT_CYCLES = 3 * NUM_PATTERNS + 50;

   logic        clk = 1'b0;
   logic        rst_n;
   instr_t      instr;
   logic        instr_valid;
   dec_ctrl_t   ctrl;
   logic        ctrl_valid;
   logic        checks_done;
   int          pass_count;
   int          error_count;
   int          cycle_count;
   logic [31:0] pattern_mem [0:2*NUM_PATTERNS-1];

   rv_decoder_top DUT (
      .clk_i         (clk),
      .rst_n_i       (rst_n),
      .instr_i       (instr),
      .instr_valid_i (instr_valid),
      .ctrl_o        (ctrl),
      .ctrl_valid_o  (ctrl_valid)
   );

   decode_checker #(
      .NUM_PATTERNS (NUM_PATTERNS)
   ) u_checker (
      .clk_i         (clk),
      .rst_n_i       (rst_n),
      .instr_valid_i (instr_valid),
      .ctrl_i        (ctrl),
      .ctrl_valid_i  (ctrl_valid),
      .done_o        (checks_done),
      .pass_count_o  (pass_count),
      .error_count_o (error_count)
   );

   always #10 clk = ~clk;

   initial begin : stimulus
      int gap;
      rst_n       = 1'b0;
      instr       = '0;
      instr_valid = 1'b0;
      void'($urandom(32'h24f4_f6d6));
      $readmemh("tests/decode_patterns.txt", pattern_mem);
      repeat (10) @(posedge clk);
      rst_n <= 1'b1;
      @(posedge clk);
      for (int i = 0; i < NUM_PATTERNS; i++) begin
         instr       <= pattern_mem[2*i];
         instr_valid <= 1'b1;
         @(posedge clk);
         // First few strobes back to back
         gap = (i < 4) ? 0 : int'($urandom % 3);
         if (gap > 0) begin
            instr_valid <= 1'b0;
            // Garbage on the bus while idle
            instr       <= $urandom;
            repeat (gap) @(posedge clk);
         end
      end
      instr_valid <= 1'b0;
   end

   initial begin : run_control
      cycle_count = 0;
      while (!checks_done && cycle_count < TIMEOUT_CYCLES) begin
         @(posedge clk);
         cycle_count = cycle_count + 1;
      end
      if (checks_done) begin
         // Catch stray results after the last pattern
         repeat (3) @(posedge clk);
      end
      if (!checks_done) begin
         $display("Timeout after %0d cycles before all results were checked", cycle_count);
         $display("Regression failed");
      end else begin
         $display("%0d patterns, %0d passed, %0d errors",
                  NUM_PATTERNS, pass_count, error_count);
         if (error_count == 0) begin
            $display("Regression passed");
         end else begin
            $display("Regression failed");
         end
      end
      $finish;
   end

endmodule

/* tests/decode_patterns.txt */
// Columns: instruction word, expected dec_ctrl_t (25 bits, is_mret in bit 24)
// Illegal encodings expect only exception = 01, i.e. 0010000
00500093 0000044 // addi x1, x0, 5
fff0a113 0004044 // slti x2, x1, -1
00209213 0003044 // slli x4, x1, 2
4030d193 0008044 // srai x3, x1, 3
002082b3 0000040 // add x5, x1, x2
40208333 00010c0 // sub x6, x1, x2
4020d3b3 0008040 // sra x7, x1, x2
0020f433 000a040 // and x8, x1, x2
0080a503 0000056 // lw x10, 8(x1)
0020a623 0000005 // sw x2, 12(x1)
00208463 000000c // beq x1, x2, +8
010000ef 000007c // jal x1, +16
000280e7 0000074 // jalr x1, 0(x5)
123455b7 000c044 // lui x11, 0x12345
00001617 000004c // auipc x12, 0x1
022086b3 0400840 // mul
022096b3 0400940 // mulh
0220a6b3 0400a40 // mulhsu
0220b6b3 0400b40 // mulhu
0220c6b3 0400c40 // div
0220d6b3 0400d40 // divu
0220e6b3 0400e40 // rem
0220f6b3 0400f40 // remu
300110f3 0e80040 // csrrw x1, mstatus, x2
300120f3 0f00040 // csrrs x1, mstatus, x2
300130f3 0f80040 // csrrc x1, mstatus, x2
3002d0f3 0ec0040 // csrrwi x1, mstatus, 5
3002e0f3 0f40040 // csrrsi x1, mstatus, 5
3002f0f3 0fc0040 // csrrci x1, mstatus, 5
00000073 0020000 // ecall
00100073 0030000 // ebreak
30200073 1000000 // mret
10500073 0000000 // wfi
0000000b 0010000 // custom-0 opcode
4020f2b3 0010000 // andn (Zbb)
60009093 0010000 // clz (Zbb)
000000f3 0010000 // ecall with rd = x1
30208073 0010000 // mret with rs1 = x1

/* tb.f */
+incdir+source
source/decode_pkg.sv
source/int_decoder.sv
source/muldiv_decoder.sv
source/system_decoder.sv
source/ctrl_merge_stage.sv
source/rv_decoder_top.sv
tests/decode_checker.sv
tests/tb_top.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing -j 0 --top-module tb_top -f tb.f -Mdir obj_dir
	@out=$$(./obj_dir/Vtb_top); \
	echo "$$out"; \
	echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf obj_dir
